// File: sim.f
rtl/aib_lane_pkg.sv
rtl/aib_apb_regs.sv
rtl/aib_tx_lane_map.sv
rtl/aib_rx_lane_map.sv
rtl/aib_lane_adapter.sv
testbench/aib_lane_checker.sv
testbench/tb_aib_lane_adapter.sv

// File: testbench/tb_aib_lane_adapter.sv
// Testbench for the AIB lane adapter, table driven APB and lane traffic with a checker beside

`timescale 1ns/1ps
`default_nettype none

module tb_aib_lane_adapter
   import aib_lane_pkg::*;
();

   localparam int DWIDTH          = 40;
   localparam int NUM_TESTS       = 12;
   localparam int N_RAND          = 6;                // Random words after the table word
   localparam int CYCLES_PER_TEST = 11 + N_RAND;      // Start, write, read, words, gap
   localparam int RESET_CYCLES    = 5;
   localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES + 20;

   logic clk, reset, psel, penable, pwrite, pready, aib_rstn, in_test;
   apb_addr_t         paddr;
   apb_data_t         pwdata, prdata, exp_rdata;
   logic [DWIDTH-1:0] tx_data, rx_data;
   aib_word_t         phy_tx_data, phy_rx_data;
   logic [8*16-1:0]   test_name;
   int                pass_count, fail_count, error_count;
   int                cycle_count = 0;
   integer            seed;

   // Stimulus table
   logic [8*16-1:0]   tab_name  [NUM_TESTS];
   apb_addr_t         tab_waddr [NUM_TESTS];
   apb_data_t         tab_wdata [NUM_TESTS];
   apb_addr_t         tab_raddr [NUM_TESTS];
   apb_data_t         tab_rdata [NUM_TESTS];     // Expected read-back
   logic [DWIDTH-1:0] tab_tx    [NUM_TESTS];
   aib_word_t         tab_rx    [NUM_TESTS];

   aib_lane_adapter #(.DWIDTH (DWIDTH)) i_dut (
      .clk (clk), .i_reset (reset),
      .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
      .i_paddr (paddr), .i_pwdata (pwdata), .o_prdata (prdata), .o_pready (pready),
      .i_tx_data (tx_data), .o_phy_tx_data (phy_tx_data),
      .i_phy_rx_data (phy_rx_data), .o_rx_data (rx_data), .o_aib_rstn (aib_rstn)
   );

   aib_lane_checker #(.DWIDTH (DWIDTH)) u_checker (
      .clk (clk), .i_reset (reset),
      .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite), .i_paddr (paddr),
      .i_pwdata (pwdata), .i_prdata (prdata), .i_pready (pready),
      .i_exp_rdata (exp_rdata),
      .i_tx_data (tx_data), .i_phy_tx_data (phy_tx_data),
      .i_phy_rx_data (phy_rx_data), .i_rx_data (rx_data), .i_aib_rstn (aib_rstn),
      .i_in_test (in_test), .i_test_name (test_name),
      .o_pass_count (pass_count), .o_fail_count (fail_count), .o_error_count (error_count)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;                         // 20 ns period
   end

   // Run limit
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout, run still going after %0d cycles", cycle_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   //--------------------------------------------------------------------------
   // Tasks
   //--------------------------------------------------------------------------

   task automatic set_entry(input int n, input logic [8*16-1:0] name, input apb_addr_t wa,
                            input apb_data_t wd, input apb_addr_t ra, input apb_data_t rd,
                            input logic [DWIDTH-1:0] tx, input aib_word_t rx);
      tab_name[n]  = name;
      tab_waddr[n] = wa;
      tab_wdata[n] = wd;
      tab_raddr[n] = ra;
      tab_rdata[n] = rd;
      tab_tx[n]    = tx;
      tab_rx[n]    = rx;
   endtask

   // Setup phase, access phase, then hold until pready closes the transfer
   task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      while (!pready) @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic run_entry(input int n);
      logic [95:0] rnd_tx;
      logic [95:0] rnd_rx;
      @(posedge clk);
      test_name <= tab_name[n];
      exp_rdata <= tab_rdata[n];
      in_test   <= 1'b1;
      apb_transfer(1'b1, tab_waddr[n], tab_wdata[n]);
      apb_transfer(1'b0, tab_raddr[n], '0);
      @(posedge clk);
      tx_data     <= tab_tx[n];
      phy_rx_data <= tab_rx[n];
      repeat (N_RAND) begin
         rnd_tx = {$random(seed), $random(seed), $random(seed)};
         rnd_rx = {$random(seed), $random(seed), $random(seed)};
         @(posedge clk);
         tx_data     <= rnd_tx[DWIDTH-1:0];
         phy_rx_data <= rnd_rx[AIB_WIDTH-1:0];
      end
      @(posedge clk);
      in_test <= 1'b0;
      repeat (2) @(posedge clk);                      // Checker closes the entry
   endtask

   //--------------------------------------------------------------------------
   // Main sequence
   //--------------------------------------------------------------------------

   initial begin
      seed        = 87298;
      reset       = 1'b1;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      tx_data     = '1;                               // Busy lanes while reset holds outputs
      phy_rx_data = '1;
      exp_rdata   = '0;
      in_test     = 1'b0;
      test_name   = '0;
      set_entry(0,  "reset_state",    12'h100, 32'h0,         12'h000, 32'h0, 40'h0, 80'h0);
      set_entry(1,  "ctrl_readback",  12'h000, 32'hFFFF_FFFF, 12'h000, 32'h7,
                40'hFF_0000_FFFF, 80'h0123_4567_89AB_CDEF_0011);
      set_entry(2,  "unmapped_read",  12'h004, 32'hFFFF_FFF0, 12'h004, 32'h0,
                40'h12_3456_789A, 80'hFFFF_0000_FFFF_0000_FFFF);
      set_entry(3,  "unmapped_write", 12'h008, 32'h0,         12'h000, 32'h7, 40'h0, 80'h0);
      set_entry(4,  "rstn_ns0_fs0",   12'h000, 32'h0,         12'h000, 32'h0, 40'h0, 80'h0);
      set_entry(5,  "rstn_ns1_fs0",   12'h000, 32'h2,         12'h000, 32'h2, 40'h0, 80'h0);
      set_entry(6,  "rstn_ns0_fs1",   12'h000, 32'h4,         12'h000, 32'h4, 40'h0, 80'h0);
      set_entry(7,  "rstn_ns1_fs1",   12'h000, 32'h6,         12'h000, 32'h6, 40'h0, 80'h0);
      set_entry(8,  "sdr_tx",         12'h000, 32'h6,         12'h000, 32'h6,
                40'hA5_C3F0_0F81, 80'h0);
      set_entry(9,  "ddr_tx",         12'h000, 32'h7,         12'h000, 32'h7,
                40'hFF_FFFF_FFFF, 80'h0);
      set_entry(10, "sdr_rx",         12'h000, 32'h0,         12'h000, 32'h0,
                40'h0, 80'hAAAA_AAAA_AAAA_AAAA_AAAA);  // Odd lanes only
      set_entry(11, "ddr_rx",         12'h000, 32'h1,         12'h000, 32'h1,
                40'h0, 80'hFFFF_FFFF_FF00_0000_0000);  // Upper lanes only
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      for (int n = 0; n < NUM_TESTS; n++) begin
         run_entry(n);
      end
      @(posedge clk);
      $display("tests %0d  passed %0d  failed %0d  mismatches %0d",
               NUM_TESTS, pass_count, fail_count, error_count);
      if (fail_count == 0 && error_count == 0 && pass_count == NUM_TESTS) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule : tb_aib_lane_adapter

`default_nettype wire

// File: testbench/aib_lane_checker.sv
// Monitor that models the AIB lane mapping and control register and compares the DUT outputs

`timescale 1ns/1ps
`default_nettype none

module aib_lane_checker
   import aib_lane_pkg::*;
#(
   parameter int DWIDTH = 40                          // Bridge width, 40 or 80
)
(
   input  wire logic              clk,
   input  wire logic              i_reset,
   input  wire logic              i_psel,             // APB as seen on the DUT ports
   input  wire logic              i_penable,
   input  wire logic              i_pwrite,
   input  wire apb_addr_t         i_paddr,
   input  wire apb_data_t         i_pwdata,
   input  wire apb_data_t         i_prdata,
   input  wire logic              i_pready,
   input  wire apb_data_t         i_exp_rdata,        // Read-back value from the table
   input  wire logic [DWIDTH-1:0] i_tx_data,
   input  wire aib_word_t         i_phy_tx_data,
   input  wire aib_word_t         i_phy_rx_data,
   input  wire logic [DWIDTH-1:0] i_rx_data,
   input  wire logic              i_aib_rstn,
   input  wire logic              i_in_test,          // High while a table entry runs
   input  wire logic [8*16-1:0]   i_test_name,        // Packed ASCII name
   output int                     o_pass_count,
   output int                     o_fail_count,
   output int                     o_error_count       // Every mismatch, in or out of a test
);

   logic [2:0]        ctrl_m;                         // Own copy of DDR, NS, FS
   aib_word_t         exp_tx;                         // Lanes expected after this edge
   logic [DWIDTH-1:0] exp_rx;
   logic              valid = 1'b0;                   // Set once an expected value exists
   logic              was_in_test = 1'b0;
   int                test_err = 0;                   // Mismatches in the running test

   initial begin
      o_pass_count  = 0;
      o_fail_count  = 0;
      o_error_count = 0;
   end

   //--------------------------------------------------------------------------
   // Reference mapping
   //--------------------------------------------------------------------------

   function automatic aib_word_t model_tx(input logic [DWIDTH-1:0] d, input logic ddr);
      aib_word_t w;
      w = '0;
      for (int i = 0; i < DWIDTH; i++) begin
         if (DWIDTH == AIB_WIDTH || ddr) begin
            w[i] = d[i];                              // Passthrough or DDR low lanes
         end else begin
            w[2*i+1] = d[i];                          // SDR odd lane
         end
      end
      return w;
   endfunction

   function automatic logic [DWIDTH-1:0] model_rx(input aib_word_t w, input logic ddr);
      logic [DWIDTH-1:0] d;
      for (int i = 0; i < DWIDTH; i++) begin
         if (DWIDTH == AIB_WIDTH || ddr) begin
            d[i] = w[i];
         end else begin
            d[i] = w[2*i];                            // SDR even lane
         end
      end
      return d;
   endfunction

   task automatic report_mismatch(input string what, input aib_word_t exp_v,
                                  input aib_word_t act_v);
      $display("FAIL %0s %0s expected %0h actual %0h", i_test_name, what, exp_v, act_v);
      test_err++;
      o_error_count++;
   endtask

   //--------------------------------------------------------------------------
   // Compare on every edge, values sampled before the edge updates them
   //--------------------------------------------------------------------------

   always @(posedge clk) begin
      if (valid) begin
         if (i_phy_tx_data !== exp_tx)
            report_mismatch("o_phy_tx_data", exp_tx, i_phy_tx_data);
         if (i_rx_data !== exp_rx)
            report_mismatch("o_rx_data", aib_word_t'(exp_rx), aib_word_t'(i_rx_data));
         if (i_aib_rstn !== (ctrl_m[CTRL_NS_RSTN_BIT] & ctrl_m[CTRL_FS_RSTN_BIT]))
            report_mismatch("o_aib_rstn", aib_word_t'(ctrl_m[1] & ctrl_m[2]),
                            aib_word_t'(i_aib_rstn));
         if (i_psel && i_penable && i_pready !== 1'b1)   // No wait states
            report_mismatch("o_pready", aib_word_t'(1'b1), aib_word_t'(i_pready));
         if (!i_reset && i_psel && i_penable && !i_pwrite && i_prdata !== i_exp_rdata)
            report_mismatch("o_prdata", aib_word_t'(i_exp_rdata), aib_word_t'(i_prdata));
      end
      if (was_in_test && !i_in_test) begin            // Entry just ended
         if (test_err == 0) begin
            $display("ok   %0s", i_test_name);
            o_pass_count++;
         end else begin
            $display("FAIL %0s with %0d mismatches", i_test_name, test_err);
            o_fail_count++;
         end
         test_err = 0;
      end
      was_in_test <= i_in_test;
      valid       <= 1'b1;
      if (i_reset) begin
         ctrl_m <= '0;
         exp_tx <= '0;                                // Outputs cleared by reset
         exp_rx <= '0;
      end else begin
         exp_tx <= model_tx(i_tx_data, ctrl_m[CTRL_DDR_BIT]);
         exp_rx <= model_rx(i_phy_rx_data, ctrl_m[CTRL_DDR_BIT]);
         if (i_psel && i_penable && i_pwrite && i_paddr == ADDR_CTRL)
            ctrl_m <= i_pwdata[2:0];                  // Only three bits stored
      end
   end

endmodule : aib_lane_checker

`default_nettype wire

// File: rtl/aib_lane_adapter.sv
// AIB lane adapter top, APB control block beside the transmit and receive lane stages

`timescale 1ns/1ps
`default_nettype none

module aib_lane_adapter
   import aib_lane_pkg::*;
#(
   parameter int DWIDTH = 40                          // Bridge width, 40 or 80
)
(
   input  wire logic              clk,                // System and APB clock
   input  wire logic              i_reset,            // Sync reset, active high

   // APB slave
   input  wire logic              i_psel,             // Select
   input  wire logic              i_penable,          // Access phase
   input  wire logic              i_pwrite,           // Direction
   input  wire apb_addr_t         i_paddr,            // Address
   input  wire apb_data_t         i_pwdata,           // Write data
   output apb_data_t              o_prdata,           // Read data
   output logic                   o_pready,           // Always ready in access

   // Bridge to PHY
   input  wire logic [DWIDTH-1:0] i_tx_data,          // Bridge transmit word
   output aib_word_t              o_phy_tx_data,      // PHY transmit lanes

   // PHY to bridge
   input  wire aib_word_t         i_phy_rx_data,      // PHY receive lanes
   output logic [DWIDTH-1:0]      o_rx_data,          // Bridge receive word

   output logic                   o_aib_rstn          // Combined NS and FS reset release
);

   logic ddr_en;                                      // Mode to both lane stages

   //--------------------------------------------------------------------------
   // Control register block
   //--------------------------------------------------------------------------

   aib_apb_regs u_regs (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_psel     (i_psel),
      .i_penable  (i_penable),
      .i_pwrite   (i_pwrite),
      .i_paddr    (i_paddr),
      .i_pwdata   (i_pwdata),
      .o_prdata   (o_prdata),
      .o_pready   (o_pready),
      .o_ddr_en   (ddr_en),                           // Fans out to TX and RX
      .o_aib_rstn (o_aib_rstn)
   );

   //--------------------------------------------------------------------------
   // Transmit path, bridge to PHY
   //--------------------------------------------------------------------------

   aib_tx_lane_map #(
      .DWIDTH (DWIDTH)
   ) u_tx_map (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_ddr_en      (ddr_en),
      .i_tx_data     (i_tx_data),
      .o_phy_tx_data (o_phy_tx_data)                  // 1 cycle after i_tx_data
   );

   //--------------------------------------------------------------------------
   // Receive path, PHY to bridge
   //--------------------------------------------------------------------------

   aib_rx_lane_map #(
      .DWIDTH (DWIDTH)
   ) u_rx_map (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_ddr_en      (ddr_en),
      .i_phy_rx_data (i_phy_rx_data),
      .o_rx_data     (o_rx_data)                      // 1 cycle after i_phy_rx_data
   );

endmodule : aib_lane_adapter

`default_nettype wire

// File: rtl/aib_rx_lane_map.sv
// Receive stage gathering bridge data back from the 80 AIB PHY lanes, one register deep

`timescale 1ns/1ps
`default_nettype none

module aib_rx_lane_map
   import aib_lane_pkg::*;
#(
   parameter int DWIDTH = 40                          // Bridge width, 40 or 80
)
(
   input  wire logic        clk,                      // System clock
   input  wire logic        i_reset,                  // Sync reset, active high
   input  wire logic        i_ddr_en,                 // 1 = DDR, 0 = SDR
   input  wire aib_word_t   i_phy_rx_data,            // PHY lane word, one per cycle
   output logic [DWIDTH-1:0] o_rx_data                // Bridge word
);

   logic [DWIDTH-1:0] map_data;                       // Bridge word ahead of the register
   logic [DWIDTH-1:0] rx_q;                           // Output register

   //--------------------------------------------------------------------------
   // Lane gather
   //--------------------------------------------------------------------------

   generate
      if (DWIDTH == AIB_WIDTH) begin : g_wide
         // Full width bridge, lanes pass straight through
         always_comb begin
            map_data = i_phy_rx_data[DWIDTH-1:0];
         end
      end else begin : g_narrow
         logic [AIB_HALF-1:0] sdr_data;               // Even lanes collected
         logic [AIB_HALF-1:0] ddr_data;               // Low lanes as they come

         // SDR picks every even lane, odd lanes ignored
         for (genvar i = 0; i < AIB_HALF; i++) begin : g_gather
            assign sdr_data[i] = i_phy_rx_data[2*i];
         end

         assign ddr_data = i_phy_rx_data[AIB_HALF-1:0];

         // Mode from the edge that samples the lanes
         always_comb begin
            if (i_ddr_en) begin
               map_data = ddr_data;
            end else begin
               map_data = sdr_data;
            end
         end
      end
   endgenerate

   //--------------------------------------------------------------------------
   // Register stage
   //--------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (i_reset) begin
         rx_q <= '0;                                  // Bridge sees zero out of reset
      end else begin
         rx_q <= map_data;                            // One cycle latency
      end
   end

   assign o_rx_data = rx_q;

   //--------------------------------------------------------------------------
   // Checks
   //--------------------------------------------------------------------------

   a_dwidth_legal: assert property (
      @(posedge clk)
      (DWIDTH == AIB_HALF) || (DWIDTH == AIB_WIDTH)
   ) else $error("aib_rx_lane_map DWIDTH must be 40 or 80");

   // Register block must hold a defined mode once out of reset
   a_ddr_en_known: assert property (
      @(posedge clk) disable iff (i_reset)
      !$isunknown(i_ddr_en)
   ) else $error("RX ddr_en unknown after reset");

endmodule : aib_rx_lane_map

`default_nettype wire

// File: rtl/aib_tx_lane_map.sv
// Transmit stage spreading bridge data onto the 80 AIB PHY lanes, one register deep

`timescale 1ns/1ps
`default_nettype none

module aib_tx_lane_map
   import aib_lane_pkg::*;
#(
   parameter int DWIDTH = 40                          // Bridge width, 40 or 80
)
(
   input  wire logic              clk,                // System clock
   input  wire logic              i_reset,            // Sync reset, active high
   input  wire logic              i_ddr_en,           // 1 = DDR, 0 = SDR
   input  wire logic [DWIDTH-1:0] i_tx_data,          // Bridge word, one per cycle
   output aib_word_t              o_phy_tx_data       // PHY lane word
);

   aib_word_t map_word;                               // Lane word ahead of the register
   aib_word_t tx_q;                                   // Output register

   //--------------------------------------------------------------------------
   // Lane mapping
   //--------------------------------------------------------------------------

   generate
      if (DWIDTH == AIB_WIDTH) begin : g_wide
         // Full width bridge, word goes straight to the lanes
         always_comb begin
            map_word = aib_word_t'(i_tx_data);
         end
      end else begin : g_narrow
         aib_word_t sdr_word;                         // Bit i on lane 2i+1
         aib_word_t ddr_word;                         // Data packed on low lanes

         // SDR spread, even lanes idle
         for (genvar i = 0; i < AIB_HALF; i++) begin : g_spread
            assign sdr_word[2*i]   = 1'b0;            // Even lane unused in SDR
            assign sdr_word[2*i+1] = i_tx_data[i];    // Odd lane carries the bit
         end

         assign ddr_word = {{AIB_HALF{1'b0}},         // Upper lanes idle
                            i_tx_data[AIB_HALF-1:0]}; // Low 40 lanes

         // Mode taken from the same edge that samples the data
         always_comb begin
            if (i_ddr_en) begin
               map_word = ddr_word;
            end else begin
               map_word = sdr_word;
            end
         end
      end
   endgenerate

   //--------------------------------------------------------------------------
   // Register stage
   //--------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (i_reset) begin
         tx_q <= '0;                                  // Lanes quiet out of reset
      end else begin
         tx_q <= map_word;                            // One cycle latency
      end
   end

   assign o_phy_tx_data = tx_q;

   //--------------------------------------------------------------------------
   // Checks
   //--------------------------------------------------------------------------

   a_dwidth_legal: assert property (
      @(posedge clk)
      (DWIDTH == AIB_HALF) || (DWIDTH == AIB_WIDTH)
   ) else $error("aib_tx_lane_map DWIDTH must be 40 or 80");

   // Mode bit comes from the register block and must be settled
   a_ddr_en_known: assert property (
      @(posedge clk) disable iff (i_reset)
      !$isunknown(i_ddr_en)
   ) else $error("TX ddr_en unknown after reset");

endmodule : aib_tx_lane_map

`default_nettype wire

// File: rtl/aib_apb_regs.sv
// APB slave holding the AIB lane control register and the combined AIB reset

`timescale 1ns/1ps
`default_nettype none

module aib_apb_regs
   import aib_lane_pkg::*;
(
   input  wire logic      clk,                        // System clock, APB runs here too
   input  wire logic      i_reset,                    // Sync reset, active high

   // APB slave
   input  wire logic      i_psel,                     // Select
   input  wire logic      i_penable,                  // Access phase
   input  wire logic      i_pwrite,                   // 1 = write, 0 = read
   input  wire apb_addr_t i_paddr,                    // Byte address
   input  wire apb_data_t i_pwdata,                   // Write data
   output apb_data_t      o_prdata,                   // Read data, valid in access phase
   output logic           o_pready,                   // No wait states

   // Control outputs
   output logic           o_ddr_en,                   // To both lane stages
   output logic           o_aib_rstn                  // NS and FS reset both released
);

   localparam int CTRL_W = CTRL_FS_RSTN_BIT + 1;      // Stored control bits

   //--------------------------------------------------------------------------
   // Access decode
   //--------------------------------------------------------------------------

   logic              access;                         // Access phase of any transfer
   logic              ctrl_sel;                       // Address hits CTRL
   logic              ctrl_wr;                        // Write strobe for CTRL
   logic              ctrl_rd;                        // Read of CTRL on the bus
   logic [CTRL_W-1:0] ctrl_q;                         // DDR, NS and FS bits

   assign access   = i_psel & i_penable;              // Setup phase has penable low
   assign ctrl_sel = (i_paddr == ADDR_CTRL);          // Single mapped register
   assign ctrl_wr  = access & i_pwrite & ctrl_sel;    // Other addresses ignored
   assign ctrl_rd  = i_psel & ~i_pwrite & ctrl_sel;   // Data ready from setup onward

   //--------------------------------------------------------------------------
   // Control register
   //--------------------------------------------------------------------------

   // Write lands on the edge that ends the access phase
   always_ff @(posedge clk) begin
      if (i_reset) begin
         ctrl_q <= '0;                                // SDR, both sides held in reset
      end else if (ctrl_wr) begin
         ctrl_q <= i_pwdata[CTRL_W-1:0];              // Upper write bits dropped
      end
   end

   //--------------------------------------------------------------------------
   // Bus outputs
   //--------------------------------------------------------------------------

   always_comb begin
      if (ctrl_rd) begin
         o_prdata = apb_data_t'(ctrl_q);              // Zero extended, upper bits read 0
      end else begin
         o_prdata = '0;                               // Unmapped or idle
      end
   end

   assign o_pready = access;                          // Every access completes at once

   // Control fan out
   assign o_ddr_en   = ctrl_q[CTRL_DDR_BIT];
   assign o_aib_rstn = ctrl_q[CTRL_NS_RSTN_BIT] &     // AND of both reset releases
                       ctrl_q[CTRL_FS_RSTN_BIT];

   //--------------------------------------------------------------------------
   // Protocol checks
   //--------------------------------------------------------------------------

   // Enable only ever rides on a selected transfer
   a_penable_needs_psel: assert property (
      @(posedge clk) disable iff (i_reset)
      i_penable |-> i_psel
   ) else $error("APB penable high without psel");

   // With pready tied to the access phase, an access phase lasts one cycle
   a_access_one_cycle: assert property (
      @(posedge clk) disable iff (i_reset)
      access |=> !i_penable
   ) else $error("APB access phase held past the completing edge");

   // An access phase is always entered from a setup phase
   a_setup_before_access: assert property (
      @(posedge clk) disable iff (i_reset)
      $rose(i_penable) |-> $past(i_psel)
   ) else $error("APB access phase without a setup phase");

endmodule : aib_apb_regs

`default_nettype wire

// File: rtl/aib_lane_pkg.sv
// Shared lane widths, APB types and control register layout for the AIB lane adapter

`default_nettype none

package aib_lane_pkg;

   //--------------------------------------------------------------------------
   // PHY lane geometry
   //--------------------------------------------------------------------------

   localparam int AIB_WIDTH = 80;                     // AIB data port is always 80 lanes
   localparam int AIB_HALF  = AIB_WIDTH / 2;          // Narrow bridge width, DDR lane count

   typedef logic [AIB_WIDTH-1:0] aib_word_t;          // One word across all PHY lanes

   //--------------------------------------------------------------------------
   // APB slave port
   //--------------------------------------------------------------------------

   typedef logic [11:0] apb_addr_t;                   // 4 KB register window
   typedef logic [31:0] apb_data_t;                   // Read and write data

   // Control register, only one mapped location
   localparam apb_addr_t ADDR_CTRL = 12'h000;

   // Control register bit positions
   localparam int CTRL_DDR_BIT     = 0;               // 1 = DDR, 0 = SDR lane spread
   localparam int CTRL_NS_RSTN_BIT = 1;               // Near side reset release
   localparam int CTRL_FS_RSTN_BIT = 2;               // Far side reset release

   // Bits above CTRL_FS_RSTN_BIT are not stored and read as zero.
   // Both reset release bits must be set before the combined AIB reset
   // is taken out of reset.

endpackage : aib_lane_pkg

`default_nettype wire
